/* Makefile */
TOP = fpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o fpu_sim

run: compile
	@out="$$(./obj_dir/fpu_sim)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+source
source/fpu_pkg.sv
source/fpu_add.sv
source/fpu_mul.sv
source/fpu_compare.sv
source/fpu.sv
testbench/fpu_tb.sv

/* source/fpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu
	import fpu_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire fpu_op_t i_op,
	input wire float_t i_op1,
	input wire float_t i_op2,
	output logic o_ready,
	output float_t o_result
);

	logic add_request;
	logic add_ready;
	float_t add_op2;
	float_t add_result;

	logic mul_request;
	logic mul_ready;
	float_t mul_result;

	logic cmp_request;
	logic cmp_ready;
	logic cmp_equal;
	logic cmp_less;

	logic sel_ready;

	// ******************************
	// Unit requests
	// ******************************
	assign add_request = i_request && (i_op == `FPU_OP_ADD || i_op == `FPU_OP_SUB);
	assign add_op2 = (i_op == `FPU_OP_SUB) ? (i_op2 ^ `FPU_SIGN_MASK) : i_op2;

	assign mul_request = i_request && (i_op == `FPU_OP_MUL);

	assign cmp_request = i_request && (
		i_op == `FPU_OP_CMP_EQUAL ||
		i_op == `FPU_OP_CMP_LESS ||
		i_op == `FPU_OP_CMP_LEQUAL ||
		i_op == `FPU_OP_MIN ||
		i_op == `FPU_OP_MAX);

	fpu_add add_unit (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(add_request),
		.i_op1(i_op1),
		.i_op2(add_op2),
		.o_ready(add_ready),
		.o_result(add_result)
	);

	fpu_mul mul_unit (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(mul_request),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(mul_ready),
		.o_result(mul_result)
	);

	fpu_compare cmp_unit (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(cmp_request),
		.i_op1(i_op1),
		.i_op2(i_op2),
		.o_ready(cmp_ready),
		.o_equal(cmp_equal),
		.o_less(cmp_less)
	);

	// ******************************
	// Result select
	// ******************************
	always_comb begin
		sel_ready = 1'b1; // Move and sign injection answer at once.
		case (i_op)
			`FPU_OP_ADD, `FPU_OP_SUB: begin
				sel_ready = add_ready;
				o_result = add_result;
			end
			`FPU_OP_MUL: begin
				sel_ready = mul_ready;
				o_result = mul_result;
			end
			`FPU_OP_MOV: o_result = i_op1;
			`FPU_OP_CMP_EQUAL: begin
				sel_ready = cmp_ready;
				o_result = {31'd0, cmp_equal};
			end
			`FPU_OP_CMP_LESS: begin
				sel_ready = cmp_ready;
				o_result = {31'd0, cmp_less};
			end
			`FPU_OP_CMP_LEQUAL: begin
				sel_ready = cmp_ready;
				o_result = {31'd0, cmp_equal | cmp_less};
			end
			`FPU_OP_SGNJ: o_result = {i_op2[31], i_op1[30:0]};
			`FPU_OP_SGNJN: o_result = {~i_op2[31], i_op1[30:0]};
			`FPU_OP_SGNJX: o_result = {i_op1[31] ^ i_op2[31], i_op1[30:0]};
			`FPU_OP_MIN: begin
				sel_ready = cmp_ready;
				o_result = cmp_less ? i_op1 : i_op2;
			end
			`FPU_OP_MAX: begin
				sel_ready = cmp_ready;
				o_result = cmp_less ? i_op2 : i_op1;
			end
			default: begin
				sel_ready = 1'b0;
				o_result = '0;
			end
		endcase
	end

	assign o_ready = i_request & sel_ready;

endmodule

`default_nettype wire

/* source/fpu_add.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_add
	import fpu_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire float_t i_op1,
	input wire float_t i_op2,
	output logic o_ready,
	output float_t o_result
);

	unit_state_t state;
	logic start;

	float_t r_op1;
	float_t r_op2;

	logic s1_sign;
	logic s1_sub;
	exp_t s1_exp;
	mant_t s1_mant_big;
	mant_t s1_mant_small;

	logic s2_sign;
	logic s2_zero;
	exp_t s2_exp;
	mant_t s2_mant;

	float_t op_big;
	float_t op_small;
	mant_t big_mant;
	mant_t small_mant;
	mant_t align_mask;
	mant_t align_mant;
	logic [7:0] align_shift;

	logic [27:0] sum;
	logic [4:0] lead_zeros;
	mant_t norm_mant;
	exp_t norm_exp;

	logic round_up;
	logic [24:0] rounded;
	exp_t round_exp;
	float_t packed_result;

	assign start = (state == IDLE) && i_request;
	assign o_ready = (state == DONE);

	// ******************************
	// Unpack and align
	// ******************************
	always_comb begin
		if (r_op1[30:0] >= r_op2[30:0]) begin
			op_big = r_op1;
			op_small = r_op2;
		end else begin
			op_big = r_op2;
			op_small = r_op1;
		end
		big_mant = (op_big[30:23] == 8'd0) ? '0 : {1'b1, op_big[22:0], 3'b000};
		small_mant = (op_small[30:23] == 8'd0) ? '0 : {1'b1, op_small[22:0], 3'b000};
		align_shift = op_big[30:23] - op_small[30:23];
		align_mask = ~(mant_t'('1) << align_shift); // Bits that fall off the bottom.
		if (align_shift > 8'd26) begin
			align_mant = {26'd0, |small_mant};
		end else begin
			align_mant = small_mant >> align_shift;
			align_mant[0] = align_mant[0] | (|(small_mant & align_mask));
		end
	end

	// ******************************
	// Add and normalize
	// ******************************
	always_comb begin
		if (s1_sub) begin
			sum = {1'b0, s1_mant_big} - {1'b0, s1_mant_small};
		end else begin
			sum = {1'b0, s1_mant_big} + {1'b0, s1_mant_small};
		end
		lead_zeros = 5'd0;
		for (int i = 0; i < 27; i++) begin
			if (sum[i]) begin
				lead_zeros = 5'(26 - i); // Highest set bit wins.
			end
		end
		if (sum[27]) begin
			norm_mant = {sum[27:2], sum[1] | sum[0]};
			norm_exp = s1_exp + exp_t'(1);
		end else begin
			norm_mant = sum[26:0] << lead_zeros;
			norm_exp = s1_exp - exp_t'({5'd0, lead_zeros});
		end
	end

	// Round to nearest, ties to even, then pack.
	always_comb begin
		round_up = s2_mant[2] & (s2_mant[1] | s2_mant[0] | s2_mant[3]);
		rounded = {1'b0, s2_mant[26:3]} + 25'(round_up);
		round_exp = s2_exp + exp_t'({9'd0, rounded[24]});
		if (s2_zero || round_exp <= exp_t'(0)) begin
			packed_result = {s2_sign, 31'd0};
		end else if (round_exp >= exp_t'(255)) begin
			packed_result = {s2_sign, 8'hFF, 23'd0};
		end else begin
			packed_result = {s2_sign, round_exp[7:0], rounded[22:0]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (i_request) state <= STAGE1;
				STAGE1: state <= STAGE2;
				STAGE2: state <= STAGE3;
				STAGE3: state <= DONE;
				default: state <= IDLE; // DONE always falls back to IDLE.
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			r_op1 <= i_op1;
			r_op2 <= i_op2;
		end
		if (state == STAGE1) begin
			s1_sign <= op_big[31];
			s1_sub <= op_big[31] ^ op_small[31]; // Effective subtraction.
			s1_exp <= exp_t'({2'b00, op_big[30:23]});
			s1_mant_big <= big_mant;
			s1_mant_small <= align_mant;
		end
		if (state == STAGE2) begin
			s2_sign <= (sum == 28'd0 && s1_sub) ? 1'b0 : s1_sign; // Exact cancel gives +0.
			s2_zero <= (sum == 28'd0);
			s2_exp <= norm_exp;
			s2_mant <= norm_mant;
		end
		if (state == STAGE3) begin
			o_result <= packed_result;
		end
	end

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_ready |=> !o_ready);

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_ready |-> $past(start, `FPU_ADD_LATENCY));

endmodule

`default_nettype wire

/* source/fpu_compare.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_compare
	import fpu_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire float_t i_op1,
	input wire float_t i_op2,
	output logic o_ready,
	output logic o_equal,
	output logic o_less
);

	logic [30:0] mag1;
	logic [30:0] mag2;
	logic equal;
	logic less;

	always_comb begin
		mag1 = (i_op1[30:23] == 8'd0) ? '0 : i_op1[30:0];
		mag2 = (i_op2[30:23] == 8'd0) ? '0 : i_op2[30:0];
		equal = (mag1 == 31'd0 && mag2 == 31'd0) || (i_op1[31] == i_op2[31] && mag1 == mag2);
		if (mag1 == 31'd0 && mag2 == 31'd0) begin
			less = 1'b0; // Plus and minus zero are the same value.
		end else if (i_op1[31] != i_op2[31]) begin
			less = i_op1[31];
		end else if (i_op1[31]) begin
			less = (mag1 > mag2); // Both negative, so the bigger magnitude is lower.
		end else begin
			less = (mag1 < mag2);
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= i_request & ~o_ready; // One pulse, then a fresh sample.
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_request && !o_ready) begin
			o_equal <= equal;
			o_less <= less;
		end
	end

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_ready |-> !(o_equal && o_less));

endmodule

`default_nettype wire

/* source/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// ******************************
// Operation codes
// ******************************
`define FPU_OP_ADD          5'd0
`define FPU_OP_SUB          5'd1
`define FPU_OP_MUL          5'd2
`define FPU_OP_MOV          5'd3
`define FPU_OP_CMP_EQUAL    5'd4
`define FPU_OP_CMP_LESS     5'd5
`define FPU_OP_CMP_LEQUAL   5'd6
`define FPU_OP_SGNJ         5'd7
`define FPU_OP_SGNJN        5'd8
`define FPU_OP_SGNJX        5'd9
`define FPU_OP_MIN          5'd10
`define FPU_OP_MAX          5'd11

`define FPU_SIGN_MASK       32'h8000_0000

`define FPU_ADD_LATENCY     4 // Cycles from the request edge to the ready pulse.
`define FPU_MUL_LATENCY     3

`endif

/* source/fpu_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_mul
	import fpu_pkg::*;
(
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire float_t i_op1,
	input wire float_t i_op2,
	output logic o_ready,
	output float_t o_result
);

	unit_state_t state;
	logic start;

	float_t r_op1;
	float_t r_op2;

	logic s1_sign;
	logic s1_zero;
	exp_t s1_exp;
	logic [47:0] s1_prod;

	logic [47:0] product;
	exp_t prod_exp;

	mant_t norm_mant;
	exp_t norm_exp;
	logic round_up;
	logic [24:0] rounded;
	exp_t round_exp;
	float_t packed_result;

	assign start = (state == IDLE) && i_request;

	assign product = {1'b1, r_op1[22:0]} * {1'b1, r_op2[22:0]};
	assign prod_exp = exp_t'({2'b00, r_op1[30:23]}) + exp_t'({2'b00, r_op2[30:23]})
		- exp_t'(127);

	// ******************************
	// Normalize, round and pack
	// ******************************
	always_comb begin
		if (s1_prod[47]) begin
			norm_mant = {s1_prod[47:22], |s1_prod[21:0]};
			norm_exp = s1_exp + exp_t'(1);
		end else begin
			norm_mant = {s1_prod[46:21], |s1_prod[20:0]};
			norm_exp = s1_exp;
		end
		round_up = norm_mant[2] & (norm_mant[1] | norm_mant[0] | norm_mant[3]);
		rounded = {1'b0, norm_mant[26:3]} + 25'(round_up);
		round_exp = norm_exp + exp_t'({9'd0, rounded[24]});
		if (s1_zero || round_exp <= exp_t'(0)) begin
			packed_result = {s1_sign, 31'd0};
		end else if (round_exp >= exp_t'(255)) begin
			packed_result = {s1_sign, 8'hFF, 23'd0};
		end else begin
			packed_result = {s1_sign, round_exp[7:0], rounded[22:0]};
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_ready <= 1'b0;
		end else begin
			o_ready <= (state == STAGE2);
			case (state)
				IDLE: if (i_request) state <= STAGE1;
				STAGE1: state <= STAGE2;
				STAGE2: state <= DONE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (start) begin
			r_op1 <= i_op1;
			r_op2 <= i_op2;
		end
		if (state == STAGE1) begin
			s1_sign <= r_op1[31] ^ r_op2[31];
			s1_zero <= (r_op1[30:23] == 8'd0) || (r_op2[30:23] == 8'd0); // Denormals too.
			s1_exp <= prod_exp;
			s1_prod <= product;
		end
		if (state == STAGE2) begin
			o_result <= packed_result;
		end
	end

	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_ready |-> (state == DONE) && $past(start, `FPU_MUL_LATENCY));

endmodule

`default_nettype wire

/* source/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

	typedef logic [31:0] float_t; // Sign in bit 31, exponent in 30:23, fraction in 22:0.

	typedef logic [4:0] fpu_op_t;

	typedef logic signed [9:0] exp_t; // Room for overflow and underflow before packing.

	typedef logic [26:0] mant_t; // Hidden bit, fraction, then guard, round and sticky.

	// Shared by the add and mul sequencers.
	typedef enum logic [2:0] {
		IDLE,
		STAGE1,
		STAGE2,
		STAGE3,
		DONE
	} unit_state_t;

endpackage

`default_nettype wire

/* testbench/fpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_tb
	import fpu_pkg::*;
;

	localparam int NUM_FIXED = 24;
	localparam int NUM_RANDOM = 8;
	localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (`FPU_ADD_LATENCY + 2) + RESET_CYCLES + 10;

	logic clock = 1'b0;
	logic rst_n;
	logic request;
	fpu_op_t op;
	float_t op1;
	float_t op2;
	logic ready;
	float_t result;

	fpu_op_t op_q[$];
	float_t op1_q[$];
	float_t op2_q[$];
	float_t expect_q[$];

	integer seed = 77196;
	int error_count = 0;
	int check_count = 0;
	int pulse_count = 0;
	logic prev_ready = 1'b0;

	fpu fpu_inst (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_request(request),
		.i_op(op),
		.i_op1(op1),
		.i_op2(op2),
		.o_ready(ready),
		.o_result(result)
	);

	always #10 clock = ~clock;

	// Counts rising edges of the ready pulse, sampled mid-cycle.
	always @(negedge clock) begin
		if (ready && !prev_ready) pulse_count++;
		prev_ready = ready;
	end

	// ******************************
	// Helpers
	// ******************************
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			$display("FAILED at %0t: %s: got %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic add_entry(input fpu_op_t e_op, input float_t a, input float_t b,
		input float_t expected);
		op_q.push_back(e_op);
		op1_q.push_back(a);
		op2_q.push_back(b);
		expect_q.push_back(expected);
	endtask

	function automatic int expected_latency(input fpu_op_t e_op);
		case (e_op)
			`FPU_OP_ADD, `FPU_OP_SUB: return `FPU_ADD_LATENCY;
			`FPU_OP_MUL: return `FPU_MUL_LATENCY;
			`FPU_OP_MOV, `FPU_OP_SGNJ, `FPU_OP_SGNJN, `FPU_OP_SGNJX: return 0;
			default: return 1; // Compare, min and max.
		endcase
	endfunction

	task automatic finish_run;
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// ******************************
	// Stimulus table
	// ******************************
	task automatic build_table;
		float_t a;
		float_t b;
		add_entry(`FPU_OP_ADD, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000); // 1.5 + 2.25.
		add_entry(`FPU_OP_SUB, 32'h3F80_0000, 32'h3F80_0000, 32'h0000_0000);
		add_entry(`FPU_OP_ADD, 32'hC0A0_0000, 32'h4000_0000, 32'hC040_0000); // -5 + 2.
		add_entry(`FPU_OP_ADD, 32'h4B80_0000, 32'h3F80_0000, 32'h4B80_0000); // Tie stays even.
		add_entry(`FPU_OP_ADD, 32'h4B80_0000, 32'h4040_0000, 32'h4B80_0002); // Tie rounds up.
		add_entry(`FPU_OP_SUB, 32'h4000_0000, 32'h4040_0000, 32'hBF80_0000);
		add_entry(`FPU_OP_MUL, 32'h4040_0000, 32'hBF00_0000, 32'hBFC0_0000); // 3 * -0.5.
		add_entry(`FPU_OP_MUL, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000);
		add_entry(`FPU_OP_MUL, 32'h0D80_0000, 32'h8D80_0000, 32'h8000_0000); // Underflow.
		add_entry(`FPU_OP_MUL, 32'h7180_0000, 32'h7180_0000, 32'h7F80_0000); // Overflow.
		add_entry(`FPU_OP_CMP_EQUAL, 32'h8000_0000, 32'h0000_0000, 32'h0000_0001);
		add_entry(`FPU_OP_CMP_LESS, 32'hC040_0000, 32'hC000_0000, 32'h0000_0001);
		add_entry(`FPU_OP_CMP_LESS, 32'hC000_0000, 32'hC040_0000, 32'h0000_0000);
		add_entry(`FPU_OP_CMP_LEQUAL, 32'h3FC0_0000, 32'h3FC0_0000, 32'h0000_0001);
		add_entry(`FPU_OP_CMP_LEQUAL, 32'hC040_0000, 32'hC000_0000, 32'h0000_0001);
		add_entry(`FPU_OP_CMP_LESS, 32'h3F80_0000, 32'hBF80_0000, 32'h0000_0000);
		add_entry(`FPU_OP_MIN, 32'hC040_0000, 32'hC000_0000, 32'hC040_0000);
		add_entry(`FPU_OP_MAX, 32'hC040_0000, 32'hC000_0000, 32'hC000_0000);
		add_entry(`FPU_OP_MIN, 32'h4000_0000, 32'h3F80_0000, 32'h3F80_0000);
		add_entry(`FPU_OP_MAX, 32'h3F80_0000, 32'h4010_0000, 32'h4010_0000);
		add_entry(`FPU_OP_MOV, 32'hC0A0_0000, 32'h3F80_0000, 32'hC0A0_0000);
		add_entry(`FPU_OP_SGNJ, 32'h3FC0_0000, 32'hBF80_0000, 32'hBFC0_0000);
		add_entry(`FPU_OP_SGNJN, 32'h3FC0_0000, 32'hBF80_0000, 32'h3FC0_0000);
		add_entry(`FPU_OP_SGNJX, 32'hBFC0_0000, 32'hBF80_0000, 32'h3FC0_0000);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			a = $random(seed);
			b = $random(seed);
			case (i % 4)
				0: add_entry(`FPU_OP_MOV, a, b, a);
				1: add_entry(`FPU_OP_SGNJ, a, b, (a & ~`FPU_SIGN_MASK) | (b & `FPU_SIGN_MASK));
				2: add_entry(`FPU_OP_SGNJN, a, b, (a & ~`FPU_SIGN_MASK) | (~b & `FPU_SIGN_MASK));
				default: add_entry(`FPU_OP_SGNJX, a, b, a ^ (b & `FPU_SIGN_MASK));
			endcase
		end
	endtask

	initial begin
		#(TIMEOUT_CYCLES * 20);
		$display("Timeout: the DUT did not finish the test table in time");
		error_count++;
		finish_run();
	end

	initial begin
		int cycles;
		rst_n = 1'b0;
		request = 1'b0;
		op = `FPU_OP_ADD;
		op1 = '0;
		op2 = '0;
		build_table();
		if (op_q.size() != NUM_ENTRIES) begin
			$display("Test table holds %0d entries instead of %0d", op_q.size(), NUM_ENTRIES);
			error_count++;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rst_n = 1'b1;
		repeat (3) begin
			@(negedge clock);
			check_value(ready, 1'b0, "o_ready after reset");
		end
		@(posedge clock);
		#1;
		for (int i = 0; i < op_q.size(); i++) begin
			op = op_q[i];
			op1 = op1_q[i];
			op2 = op2_q[i];
			request = 1'b1;
			cycles = 0;
			@(negedge clock);
			while (!ready && cycles < `FPU_ADD_LATENCY + 2) begin
				cycles++;
				@(negedge clock);
			end
			if (!ready) begin
				$display("Entry %0d got no ready pulse from the DUT", i);
				error_count++;
			end else begin
				check_value(cycles, expected_latency(op_q[i]), $sformatf("entry %0d latency", i));
				check_value(result, expect_q[i], $sformatf("entry %0d result", i));
			end
			@(posedge clock);
			#1 request = 1'b0;
			@(negedge clock);
			check_value(ready, 1'b0, $sformatf("entry %0d o_ready when idle", i));
			@(posedge clock);
			#1;
		end
		check_value(pulse_count, op_q.size(), "ready pulse count"); // One pulse per entry.
		finish_run();
	end

endmodule

`default_nettype wire
